// File: common/opnd_pkg.sv
/*
 * Operand subsystem package
 * Register file geometry, register address and data types, the 2-bit
 * ALU opcode and the shared ALU function of the execute stage
 */
package opnd_pkg;

  //////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////

  // 32 addresses, register 0 reads as zero
  localparam int ADDR_W   = 5;
  localparam int DATA_W   = 32;
  localparam int NUM_REGS = 2 ** ADDR_W;

  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] reg_data_t;

  //////////////////////////////////////////////////
  // ALU opcodes
  //////////////////////////////////////////////////

  // Only OP_ADD3 reads the third source
  typedef enum logic [1:0] {
    OP_ADD  = 2'b00,
    OP_SUB  = 2'b01,
    OP_XOR  = 2'b10,
    OP_ADD3 = 2'b11
  } alu_op_e;

  // Result of one operation, all arithmetic wraps modulo 2^32
  function automatic reg_data_t alu_compute(alu_op_e op, reg_data_t a, reg_data_t b,
                                            reg_data_t c);
    reg_data_t res;
    res = '0;
    unique case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_XOR:  res = a ^ b;
      OP_ADD3: res = a + b + c;
      default: res = '0;
    endcase
    return res;
  endfunction

endpackage

// File: common/issue_if.sv
/*
 * Issue bus between issue stage and execute stage
 * One operation per valid/ready transfer: opcode, destination
 * and the three operand values read from the register file
 */
interface issue_if;
  import opnd_pkg::*;

  // Handshake
  logic      valid;
  logic      ready;

  // Operation payload
  alu_op_e   op;
  reg_addr_t rd;
  // Operand values, opc only matters for OP_ADD3
  reg_data_t opa;
  reg_data_t opb;
  reg_data_t opc;

  // Producer side, held by the issue stage
  modport issue (
    output valid, op, rd, opa, opb, opc,
    input  ready
  );

  // Consumer side, held by the execute stage
  modport exec (
    input  valid, op, rd, opa, opb, opc,
    output ready
  );

endinterface

// File: regfile/regfile_3r2w.sv
/*
 * Flip-flop register file, 31 usable registers of 32 bits
 * Register 0 is a constant zero and ignores writes
 * Three combinational read ports, two write ports, and port B
 * wins when both ports write the same register at one edge
 */
module regfile_3r2w (
  input  logic                clk,
  input  logic                rst_n,

  // Read ports
  input  opnd_pkg::reg_addr_t raddr_a_i,
  input  opnd_pkg::reg_addr_t raddr_b_i,
  input  opnd_pkg::reg_addr_t raddr_c_i,
  output opnd_pkg::reg_data_t rdata_a_o,
  output opnd_pkg::reg_data_t rdata_b_o,
  output opnd_pkg::reg_data_t rdata_c_o,

  // Write port A from the execute stage write-back
  input  logic                we_a_i,
  input  opnd_pkg::reg_addr_t waddr_a_i,
  input  opnd_pkg::reg_data_t wdata_a_i,

  // Write port B from the external writer
  input  logic                we_b_i,
  input  opnd_pkg::reg_addr_t waddr_b_i,
  input  opnd_pkg::reg_data_t wdata_b_i
);
  import opnd_pkg::*;

  // Storage for registers 1..31 only
  reg_data_t [NUM_REGS-1:1] rf_q;
  // Full view including the zero register for the read muxes
  reg_data_t [NUM_REGS-1:0] rf_all;

  // One write enable per register and port
  logic [NUM_REGS-1:1] we_a_dec;
  logic [NUM_REGS-1:1] we_b_dec;

  //////////////////////////////////////////////////
  // Write address decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 1; i < NUM_REGS; i++) begin
      we_a_dec[i] = we_a_i && (waddr_a_i == reg_addr_t'(i));
      we_b_dec[i] = we_b_i && (waddr_b_i == reg_addr_t'(i));
    end
  end

  //////////////////////////////////////////////////
  // Register storage
  //////////////////////////////////////////////////

  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rf_q[i] <= '0;
      end else if (we_b_dec[i]) begin
        // External writer has priority
        rf_q[i] <= wdata_b_i;
      end else if (we_a_dec[i]) begin
        rf_q[i] <= wdata_a_i;
      end
    end
  end

  // Register 0 tied off below the stored words
  assign rf_all = {rf_q, {DATA_W{1'b0}}};

  // Combinational reads from the current state
  assign rdata_a_o = rf_all[raddr_a_i];
  assign rdata_b_o = rf_all[raddr_b_i];
  assign rdata_c_o = rf_all[raddr_c_i];

  // Port B data lands in its register even when port A hits the same one
  a_port_b_wins : assert property (@(posedge clk) disable iff (!rst_n)
    (we_b_i && (waddr_b_i != '0)) |=> (rf_all[$past(waddr_b_i)] == $past(wdata_b_i)))
    else $error("port B write lost");

endmodule

// File: source/operand_issue.sv
/*
 * Issue stage
 * Accepts requests over valid/ready, reads up to three operands
 * from the register file and passes them to the execute stage
 * Stalls a request whose source is the pending destination
 */
module operand_issue (
  input  logic                clk,
  input  logic                rst_n,

  // Request stream
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  opnd_pkg::alu_op_e   instr_op_i,
  input  opnd_pkg::reg_addr_t instr_rs1_i,
  input  opnd_pkg::reg_addr_t instr_rs2_i,
  input  opnd_pkg::reg_addr_t instr_rs3_i,
  input  opnd_pkg::reg_addr_t instr_rd_i,

  // Register file read ports
  output opnd_pkg::reg_addr_t raddr_a_o,
  output opnd_pkg::reg_addr_t raddr_b_o,
  output opnd_pkg::reg_addr_t raddr_c_o,
  input  opnd_pkg::reg_data_t rdata_a_i,
  input  opnd_pkg::reg_data_t rdata_b_i,
  input  opnd_pkg::reg_data_t rdata_c_i,

  // Destination still held by the execute stage
  input  logic                pend_valid_i,
  input  opnd_pkg::reg_addr_t pend_rd_i,

  issue_if.issue              iss
);
  import opnd_pkg::*;

  logic uses_rs3;
  logic pend_live;
  logic hit_rs1;
  logic hit_rs2;
  logic hit_rs3;
  logic hazard;

  // Sources go straight to the read ports
  assign raddr_a_o = instr_rs1_i;
  assign raddr_b_o = instr_rs2_i;
  assign raddr_c_o = instr_rs3_i;

  //////////////////////////////////////////////////
  // Hazard check against the pending destination
  //////////////////////////////////////////////////

  assign uses_rs3 = (instr_op_i == OP_ADD3);
  // A pending write to register 0 never blocks anything
  assign pend_live = pend_valid_i && (pend_rd_i != '0);

  assign hit_rs1 = pend_live && (pend_rd_i == instr_rs1_i);
  assign hit_rs2 = pend_live && (pend_rd_i == instr_rs2_i);
  assign hit_rs3 = pend_live && uses_rs3 && (pend_rd_i == instr_rs3_i);
  assign hazard  = hit_rs1 || hit_rs2 || hit_rs3;

  // Offer the operation only once its sources are settled
  assign iss.valid = instr_valid_i && !hazard;
  assign iss.op    = instr_op_i;
  assign iss.rd    = instr_rd_i;
  assign iss.opa   = rdata_a_i;
  assign iss.opb   = rdata_b_i;
  assign iss.opc   = rdata_c_i;

  // Execute stage room and no hazard
  assign instr_ready_o = iss.ready && !hazard;

  // A transfer leaves its destination pending for the next stall check
  a_pend_follows_issue : assert property (@(posedge clk) disable iff (!rst_n)
    (iss.valid && iss.ready) |=> (pend_valid_i && (pend_rd_i == $past(instr_rd_i))))
    else $error("issued destination not pending in the execute stage");

endmodule

// File: source/exec_stage.sv
/*
 * Execute stage
 * Computes one ALU operation per transfer and holds the result
 * with its destination until the result stream accepts it
 * The accepted result is written back through write port A
 */
module exec_stage (
  input  logic                clk,
  input  logic                rst_n,

  issue_if.exec               iss,

  // Result stream
  output logic                result_valid_o,
  input  logic                result_ready_i,
  output opnd_pkg::reg_addr_t result_rd_o,
  output opnd_pkg::reg_data_t result_data_o,

  // Pending destination for the stall check
  output logic                pend_valid_o,
  output opnd_pkg::reg_addr_t pend_rd_o,

  // Write port A
  output logic                wa_we_o,
  output opnd_pkg::reg_addr_t wa_addr_o,
  output opnd_pkg::reg_data_t wa_data_o
);
  import opnd_pkg::*;

  logic      res_valid_q;
  reg_addr_t res_rd_q;
  reg_data_t res_data_q;

  logic      take;
  logic      retire;
  reg_data_t alu_res;

  // Room when empty or when the held result leaves this cycle
  assign iss.ready = !res_valid_q || result_ready_i;
  assign take      = iss.valid && iss.ready;
  assign retire    = res_valid_q && result_ready_i;

  assign alu_res = alu_compute(iss.op, iss.opa, iss.opb, iss.opc);

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else if (take) begin
      res_valid_q <= 1'b1;
    end else if (retire) begin
      res_valid_q <= 1'b0;
    end
  end

  // Payload only loads on a transfer
  always_ff @(posedge clk) begin
    if (take) begin
      res_rd_q   <= iss.rd;
      res_data_q <= alu_res;
    end
  end

  assign result_valid_o = res_valid_q;
  assign result_rd_o    = res_rd_q;
  assign result_data_o  = res_data_q;

  assign pend_valid_o = res_valid_q;
  assign pend_rd_o    = res_rd_q;

  // Write-back on the same edge as the result handshake
  // A result for rd 0 goes out too, the register file drops it
  assign wa_we_o   = retire;
  assign wa_addr_o = res_rd_q;
  assign wa_data_o = res_data_q;

  // Back-pressure holds the offered result unchanged
  a_result_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (result_valid_o && !result_ready_i) |=>
      (result_valid_o && $stable(result_rd_o) && $stable(result_data_o)))
    else $error("result changed while stalled");

endmodule

// File: source/operand_core_top.sv
/*
 * Operand subsystem top level
 * Register file, issue stage and execute stage, with a request
 * stream in, a result stream out and an external write port
 */
module operand_core_top (
  input  logic                clk,
  input  logic                rst_n,

  // Request stream
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  opnd_pkg::alu_op_e   instr_op_i,
  input  opnd_pkg::reg_addr_t instr_rs1_i,
  input  opnd_pkg::reg_addr_t instr_rs2_i,
  input  opnd_pkg::reg_addr_t instr_rs3_i,
  input  opnd_pkg::reg_addr_t instr_rd_i,

  // Result stream
  output logic                result_valid_o,
  input  logic                result_ready_i,
  output opnd_pkg::reg_addr_t result_rd_o,
  output opnd_pkg::reg_data_t result_data_o,

  // External writer on port B, always taken
  input  logic                ext_we_i,
  input  opnd_pkg::reg_addr_t ext_waddr_i,
  input  opnd_pkg::reg_data_t ext_wdata_i
);
  import opnd_pkg::*;

  // Read ports
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_addr_t raddr_c;
  reg_data_t rdata_a;
  reg_data_t rdata_b;
  reg_data_t rdata_c;

  // Pending destination
  logic      pend_valid;
  reg_addr_t pend_rd;

  // Write-back on port A
  logic      wa_we;
  reg_addr_t wa_addr;
  reg_data_t wa_data;

  issue_if iss_bus ();

  regfile_3r2w u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .raddr_c_i (raddr_c),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_c_o (rdata_c),
    .we_a_i    (wa_we),
    .waddr_a_i (wa_addr),
    .wdata_a_i (wa_data),
    .we_b_i    (ext_we_i),
    .waddr_b_i (ext_waddr_i),
    .wdata_b_i (ext_wdata_i)
  );

  operand_issue u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_op_i    (instr_op_i),
    .instr_rs1_i   (instr_rs1_i),
    .instr_rs2_i   (instr_rs2_i),
    .instr_rs3_i   (instr_rs3_i),
    .instr_rd_i    (instr_rd_i),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .raddr_c_o     (raddr_c),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .rdata_c_i     (rdata_c),
    .pend_valid_i  (pend_valid),
    .pend_rd_i     (pend_rd),
    .iss           (iss_bus.issue)
  );

  exec_stage u_exec (
    .clk            (clk),
    .rst_n          (rst_n),
    .iss            (iss_bus.exec),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .pend_valid_o   (pend_valid),
    .pend_rd_o      (pend_rd),
    .wa_we_o        (wa_we),
    .wa_addr_o      (wa_addr),
    .wa_data_o      (wa_data)
  );

endmodule

// File: testbench/tb_operand_core.sv
/*
 * Testbench for the operand subsystem top level
 * Random requests, result back-pressure and external writes,
 * checked cycle by cycle against a register file model
 */
module tb_operand_core;
  timeunit 1ns;
  timeprecision 100ps;
  import opnd_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int NUM_REQ       = 2000;
  localparam int WARMUP_REQ    = 16;
  localparam int WATCHDOG_NS   = NUM_REQ * 20 * CLK_PERIOD_NS;

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  logic      instr_ready_o;
  alu_op_e   instr_op_i;
  reg_addr_t instr_rs1_i;
  reg_addr_t instr_rs2_i;
  reg_addr_t instr_rs3_i;
  reg_addr_t instr_rd_i;
  logic      result_valid_o;
  logic      result_ready_i;
  reg_addr_t result_rd_o;
  reg_data_t result_data_o;
  logic      ext_we_i;
  reg_addr_t ext_waddr_i;
  reg_data_t ext_wdata_i;

  integer    seed = 32'h07d90f42;

  // Model state and results still owed by the DUT, oldest first
  reg_data_t model_rf [NUM_REGS];
  reg_addr_t exp_rd_q [$];
  reg_data_t exp_data_q [$];

  int        test_num;
  int        test_checks;
  int        test_errors;
  int        total_checks;
  int        total_errors;
  // Same-edge hits of write-back and external write
  int        collisions;

  operand_core_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_op_i     (instr_op_i),
    .instr_rs1_i    (instr_rs1_i),
    .instr_rs2_i    (instr_rs2_i),
    .instr_rs3_i    (instr_rs3_i),
    .instr_rd_i     (instr_rd_i),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .ext_we_i       (ext_we_i),
    .ext_waddr_i    (ext_waddr_i),
    .ext_wdata_i    (ext_wdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Model and compare tasks
  //////////////////////////////////////////////////

  // Opcode rules, all sums wrap at 32 bits
  function automatic reg_data_t expected_alu(alu_op_e op, reg_data_t a, reg_data_t b,
                                             reg_data_t c);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return a + b + c;
    endcase
  endfunction

  // Register 0 stays zero
  task automatic model_write(input reg_addr_t addr, input reg_data_t data);
    if (addr != '0) begin
      model_rf[addr] = data;
    end
  endtask

  task automatic check_result(input string what, input reg_addr_t got_rd,
                              input reg_data_t got_data, input reg_addr_t exp_rd,
                              input reg_data_t exp_data);
    test_checks++;
    if (got_rd !== exp_rd || got_data !== exp_data) begin
      test_errors++;
      $display("CHECK FAILED at %0t: %s rd %0d data %08h, expected rd %0d data %08h",
               $time, what, got_rd, got_data, exp_rd, exp_data);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("Test %0d %s: %0d checks, %0d errors", test_num, name, test_checks,
             test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Small register set so hazards and collisions are common
  function automatic reg_addr_t pick_reg();
    return reg_addr_t'($unsigned($random(seed)) % 8);
  endfunction

  task automatic drive_next(input bit more, input bit ext_on, input logic taken);
    // A waiting request is held until it is taken
    if (taken || !instr_valid_i) begin
      if (more && ($unsigned($random(seed)) % 4 != 0)) begin
        instr_valid_i <= 1'b1;
        instr_op_i    <= alu_op_e'(2'($unsigned($random(seed))));
        instr_rs1_i   <= pick_reg();
        instr_rs2_i   <= pick_reg();
        instr_rs3_i   <= pick_reg();
        instr_rd_i    <= pick_reg();
      end else begin
        instr_valid_i <= 1'b0;
      end
    end
    // Consumer stalls about 30% of cycles
    result_ready_i <= ($unsigned($random(seed)) % 10) >= 3;
    ext_we_i       <= ext_on && ($unsigned($random(seed)) % 4 == 0);
    ext_waddr_i    <= pick_reg();
    ext_wdata_i    <= $random(seed);
  endtask

  // Runs n requests, then drains the results still owed
  task automatic run_traffic(input int n, input bit ext_on);
    int        issued;
    logic      hs_req;
    logic      hs_res;
    logic      hazard;
    logic      exp_ready;
    reg_addr_t wb_rd;
    reg_data_t wb_data;
    reg_data_t req_data;
    issued = 0;
    req_data = '0;
    while (issued < n || exp_rd_q.size() != 0) begin
      @(posedge clk);
      hs_req = instr_valid_i && instr_ready_o;
      hs_res = result_valid_o && result_ready_i;
      // Stall rule against the held result's destination
      hazard = 1'b0;
      if (exp_rd_q.size() != 0 && exp_rd_q[0] != '0) begin
        wb_rd  = exp_rd_q[0];
        hazard = (wb_rd == instr_rs1_i) || (wb_rd == instr_rs2_i) ||
                 (instr_op_i == OP_ADD3 && wb_rd == instr_rs3_i);
      end
      exp_ready = !hazard && (exp_rd_q.size() == 0 || result_ready_i);
      check_flag("instr_ready_o", instr_ready_o, exp_ready);
      // One cycle after each request the result must be up
      check_flag("result_valid_o", result_valid_o, exp_rd_q.size() != 0);
      // Also holds the payload steady across stalled cycles
      if (result_valid_o && exp_rd_q.size() != 0) begin
        check_result("result", result_rd_o, result_data_o, exp_rd_q[0], exp_data_q[0]);
      end
      // Operands as they stood before this edge
      if (hs_req) begin
        req_data = expected_alu(instr_op_i, model_rf[instr_rs1_i], model_rf[instr_rs2_i],
                                model_rf[instr_rs3_i]);
        issued++;
      end
      // Write-back first, so the external write wins
      if (hs_res && exp_rd_q.size() != 0) begin
        wb_rd   = exp_rd_q.pop_front();
        wb_data = exp_data_q.pop_front();
        if (ext_we_i && ext_waddr_i == wb_rd && wb_rd != '0) begin
          collisions++;
        end
        model_write(wb_rd, wb_data);
      end
      if (ext_we_i) begin
        model_write(ext_waddr_i, ext_wdata_i);
      end
      if (hs_req) begin
        exp_rd_q.push_back(instr_rd_i);
        exp_data_q.push_back(req_data);
      end
      drive_next(issued < n, ext_on, hs_req);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    instr_valid_i  = 1'b0;
    instr_op_i     = OP_ADD;
    instr_rs1_i    = '0;
    instr_rs2_i    = '0;
    instr_rs3_i    = '0;
    instr_rd_i     = '0;
    result_ready_i = 1'b0;
    ext_we_i       = 1'b0;
    ext_waddr_i    = '0;
    ext_wdata_i    = '0;
    test_num       = 0;
    test_checks    = 0;
    test_errors    = 0;
    total_checks   = 0;
    total_errors   = 0;
    collisions     = 0;
    foreach (model_rf[i]) begin
      model_rf[i] = '0;
    end

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag("result_valid_o after reset", result_valid_o, 1'b0);
    check_flag("instr_ready_o after reset", instr_ready_o, 1'b1);
    report_test("reset state");

    // No external writes yet, every register still zero
    run_traffic(WARMUP_REQ, 1'b0);
    report_test("operations on zero registers");

    run_traffic(NUM_REQ - WARMUP_REQ, 1'b1);
    check_flag("write-back and external write collided", collisions != 0, 1'b1);
    report_test("random traffic with external writes");

    $display("Done: %0d checks, %0d errors, %0d write collisions", total_checks,
             total_errors, collisions);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Generous bound of 20 cycles per request
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: files.f
common/opnd_pkg.sv
common/issue_if.sv
regfile/regfile_3r2w.sv
source/operand_issue.sv
source/exec_stage.sv
source/operand_core_top.sv
testbench/tb_operand_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_operand_core
FILELIST  = files.f
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
